//--- include/xbus_consts.svh
/*
 * XBus register map constants
 * Address map, reset values and memory depth of the slave register file
 */
`ifndef XBUS_CONSTS_SVH
`define XBUS_CONSTS_SVH

// Address map ------------------------
`define XBUS_ADDR_PTR       16'h1008
`define XBUS_ADDR_CONFIG    16'h1009
`define XBUS_ADDR_USER      16'h100A
`define XBUS_ADDR_SHARED    16'h100B
`define XBUS_ADDR_INDIRECT  16'h100C
`define XBUS_ADDR_RW_BASE   16'h1010
`define XBUS_ADDR_RO_BASE   16'h1014
`define XBUS_ADDR_WO_BASE   16'h1018
`define XBUS_ADDR_MEM_BASE  16'h1100
`define XBUS_MEM_DEPTH      256

// Reset values -----------------------
`define XBUS_RST_PTR        8'h01
`define XBUS_RST_CONFIG     8'hF0
`define XBUS_RST_SHARED_RD  8'hA5
`define XBUS_RST_RW         8'h5A
`define XBUS_RST_RO         8'hA5
`define XBUS_RST_WO         8'h55

`endif

//--- rtl/xbus_arbiter.sv
/*
 * XBus arbiter
 * Runs the start, arbitrate, address and data phases and grants one of two
 * masters, master 0 first
 */
`timescale 1ns/1ps

module xbus_arbiter (
  input  logic                  xbus_clock,
  input  logic                  xbus_reset,
  input  logic                  m0_request,
  input  logic                  m1_request,
  input  logic                  done,
  output xbus_pkg::xbus_phase_e phase,
  output logic [1:0]            grant
);

  xbus_pkg::xbus_phase_e phase_q;
  logic [1:0]            grant_q;

  // Phase sequencer ------------------------------
  // Grant is registered out of ARBITRATE, so it is high in ADDRESS only
  always_ff @(posedge xbus_clock or posedge xbus_reset) begin
    if (xbus_reset) begin
      phase_q <= xbus_pkg::IDLE_START;
      grant_q <= 2'b00;
    end else begin
      grant_q <= 2'b00;
      case (phase_q)
        xbus_pkg::IDLE_START: begin
          // One-cycle start pulse
          phase_q <= xbus_pkg::ARBITRATE;
        end
        xbus_pkg::ARBITRATE: begin
          if (m0_request) begin
            phase_q <= xbus_pkg::ADDRESS;
            grant_q <= 2'b01;
          end else if (m1_request) begin
            phase_q <= xbus_pkg::ADDRESS;
            grant_q <= 2'b10;
          end else begin
            // Nobody asked, issue another start
            phase_q <= xbus_pkg::IDLE_START;
          end
        end
        xbus_pkg::ADDRESS: begin
          phase_q <= xbus_pkg::DATA;
        end
        xbus_pkg::DATA: begin
          if (done) begin
            phase_q <= xbus_pkg::IDLE_START;
          end
        end
        default: begin
          phase_q <= xbus_pkg::IDLE_START;
        end
      endcase
    end
  end

  assign phase = phase_q;
  assign grant = grant_q;

  // Checks ------------------------------
  grant_onehot_a: assert property (
    @(posedge xbus_clock) disable iff (xbus_reset) $onehot0(grant_q)
  );

  // Done comes back from the register file through the controller
  done_in_data_a: assert property (
    @(posedge xbus_clock) disable iff (xbus_reset) done |-> phase_q == xbus_pkg::DATA
  );

endmodule

//--- rtl/xbus_pkg.sv
/*
 * XBus shared types
 * Master command and response, register file access, bus phase, config byte
 */
package xbus_pkg;

  // Command held by one master until done
  typedef struct packed {
    logic        request;
    logic        read;
    logic        write;
    logic [15:0] addr;
    logic [7:0]  wdata;
  } xbus_master_req_t;

  typedef struct packed {
    logic       grant;
    logic       done;
    logic       error;
    logic [7:0] rdata;
  } xbus_master_rsp_t;

  // Single-cycle command into the register file
  typedef struct packed {
    logic        valid;
    logic        read;
    logic [15:0] addr;
    logic [7:0]  wdata;
  } xbus_access_t;

  typedef struct packed {
    logic       done;
    logic       error;
    logic [7:0] rdata;
  } xbus_result_t;

  typedef enum logic [1:0] {
    IDLE_START,
    ARBITRATE,
    ADDRESS,
    DATA
  } xbus_phase_e;

  // Config byte, seen whole or as its fields
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic [3:0] rsvd;
      logic [1:0] kind;
      logic [1:0] dest;
    } fields;
  } xbus_config_u;

endpackage

//--- rtl/xbus_register_file.sv
/*
 * XBus register file
 * Byte-wide slave with pointer, config, counter, shared, indirect and block
 * registers and a 256-byte memory. Unmapped addresses end with an error
 */
`timescale 1ns/1ps
`include "xbus_consts.svh"

module xbus_register_file (
  input  logic                   xbus_clock,
  input  logic                   xbus_reset,
  input  xbus_pkg::xbus_access_t access,
  output xbus_pkg::xbus_result_t result
);

  logic [2:0]             ptr_q;
  xbus_pkg::xbus_config_u config_q;
  logic [7:0]             user_q;
  // Hidden write side of the shared register
  logic [7:0]             shared_wr_q;
  logic [7:0]             indirect_q [8];
  logic [7:0]             rw_q [4];
  logic [7:0]             wo_q [4];
  logic [7:0]             mem_q [`XBUS_MEM_DEPTH];

  logic       sel_ptr;
  logic       sel_config;
  logic       sel_user;
  logic       sel_shared;
  logic       sel_indirect;
  logic       sel_rw;
  logic       sel_ro;
  logic       sel_wo;
  logic       sel_mem;
  logic       hit;
  logic       wr_en;
  logic [7:0] rd_value;

  // Address decode ------------------------------
  assign sel_ptr      = access.addr == `XBUS_ADDR_PTR;
  assign sel_config   = access.addr == `XBUS_ADDR_CONFIG;
  assign sel_user     = access.addr == `XBUS_ADDR_USER;
  assign sel_shared   = access.addr == `XBUS_ADDR_SHARED;
  assign sel_indirect = access.addr == `XBUS_ADDR_INDIRECT;
  // Four-register blocks on 4-byte boundaries
  assign sel_rw       = (access.addr & 16'hFFFC) == `XBUS_ADDR_RW_BASE;
  assign sel_ro       = (access.addr & 16'hFFFC) == `XBUS_ADDR_RO_BASE;
  assign sel_wo       = (access.addr & 16'hFFFC) == `XBUS_ADDR_WO_BASE;
  assign sel_mem      = (access.addr & 16'hFF00) == `XBUS_ADDR_MEM_BASE;

  assign hit = sel_ptr | sel_config | sel_user | sel_shared | sel_indirect |
               sel_rw | sel_ro | sel_wo | sel_mem;

  assign wr_en = access.valid && !access.read && hit;

  // Read mux where the write-only block falls through to zero
  always_comb begin
    rd_value = 8'h00;
    if (sel_ptr) begin
      rd_value = {5'b00000, ptr_q};
    end else if (sel_config) begin
      rd_value = config_q.raw;
    end else if (sel_user) begin
      rd_value = user_q;
    end else if (sel_shared) begin
      rd_value = `XBUS_RST_SHARED_RD;
    end else if (sel_indirect) begin
      rd_value = indirect_q[ptr_q];
    end else if (sel_rw) begin
      rd_value = rw_q[access.addr[1:0]];
    end else if (sel_ro) begin
      // Read-only block stays at its reset value
      rd_value = `XBUS_RST_RO;
    end else if (sel_mem) begin
      rd_value = mem_q[access.addr[7:0]];
    end
  end

  // Registers and response ------------------------------
  always_ff @(posedge xbus_clock or posedge xbus_reset) begin
    if (xbus_reset) begin
      ptr_q        <= 3'(`XBUS_RST_PTR);
      config_q.raw <= `XBUS_RST_CONFIG;
      user_q       <= 8'h00;
      shared_wr_q  <= 8'h00;
      for (int i = 0; i < 8; i++) begin
        indirect_q[i] <= 8'h00;
      end
      for (int i = 0; i < 4; i++) begin
        rw_q[i] <= `XBUS_RST_RW;
        wo_q[i] <= `XBUS_RST_WO;
      end
      result <= '0;
    end else begin
      // Answer one cycle after every access
      result.done  <= access.valid;
      result.error <= access.valid && !hit;
      result.rdata <= (access.valid && access.read && hit) ? rd_value : 8'h00;
      if (wr_en) begin
        if (sel_ptr) begin
          ptr_q <= access.wdata[2:0];
        end
        if (sel_config) begin
          config_q.raw <= access.wdata;
        end
        if (sel_user) begin
          // Counts writes whatever the data
          user_q <= user_q + 8'd1;
        end
        if (sel_shared) begin
          shared_wr_q <= access.wdata;
        end
        if (sel_indirect) begin
          indirect_q[ptr_q] <= access.wdata;
        end
        if (sel_rw) begin
          rw_q[access.addr[1:0]] <= access.wdata;
        end
        if (sel_wo) begin
          wo_q[access.addr[1:0]] <= access.wdata;
        end
      end
    end
  end

  // Memory array
  always_ff @(posedge xbus_clock) begin
    if (wr_en && sel_mem) begin
      mem_q[access.addr[7:0]] <= access.wdata;
    end
  end

  // One answer per access and no new access while the answer is out
  done_follows_access_a: assert property (
    @(posedge xbus_clock) disable iff (xbus_reset)
    access.valid |=> result.done && !access.valid
  );

endmodule

//--- rtl/xbus_subsystem_top.sv
/*
 * XBus slave subsystem
 * Arbiter, transfer controller and register file for two masters
 */
`timescale 1ns/1ps

module xbus_subsystem_top (
  input  logic                       xbus_clock,
  input  logic                       xbus_reset,
  input  xbus_pkg::xbus_master_req_t m0_req,
  input  xbus_pkg::xbus_master_req_t m1_req,
  output xbus_pkg::xbus_master_rsp_t m0_rsp,
  output xbus_pkg::xbus_master_rsp_t m1_rsp
);

  xbus_pkg::xbus_phase_e  phase;
  logic [1:0]             grant;
  logic                   done;
  xbus_pkg::xbus_access_t access;
  xbus_pkg::xbus_result_t result;

  xbus_arbiter arbiter_i (
    .xbus_clock (xbus_clock),
    .xbus_reset (xbus_reset),
    .m0_request (m0_req.request),
    .m1_request (m1_req.request),
    .done       (done),
    .phase      (phase),
    .grant      (grant)
  );

  xbus_transfer_control transfer_control_i (
    .xbus_clock (xbus_clock),
    .xbus_reset (xbus_reset),
    .m0_req     (m0_req),
    .m1_req     (m1_req),
    .phase      (phase),
    .grant      (grant),
    .access     (access),
    .result     (result),
    .done       (done),
    .m0_rsp     (m0_rsp),
    .m1_rsp     (m1_rsp)
  );

  xbus_register_file register_file_i (
    .xbus_clock (xbus_clock),
    .xbus_reset (xbus_reset),
    .access     (access),
    .result     (result)
  );

endmodule

//--- rtl/xbus_transfer_control.sv
/*
 * XBus transfer controller
 * Steers the granted master's command into the register file and returns
 * the result to that master alone
 */
`timescale 1ns/1ps

module xbus_transfer_control (
  input  logic                       xbus_clock,
  input  logic                       xbus_reset,
  input  xbus_pkg::xbus_master_req_t m0_req,
  input  xbus_pkg::xbus_master_req_t m1_req,
  input  xbus_pkg::xbus_phase_e      phase,
  input  logic [1:0]                 grant,
  output xbus_pkg::xbus_access_t     access,
  input  xbus_pkg::xbus_result_t     result,
  output logic                       done,
  output xbus_pkg::xbus_master_rsp_t m0_rsp,
  output xbus_pkg::xbus_master_rsp_t m1_rsp
);

  xbus_pkg::xbus_master_req_t sel_req;
  logic                       owner_q;

  // Command of the granted master, held stable by the master rule
  assign sel_req = grant[1] ? m1_req : m0_req;

  always_comb begin
    access.valid = (phase == xbus_pkg::ADDRESS) && (grant != 2'b00);
    access.read  = sel_req.read;
    access.addr  = sel_req.addr;
    access.wdata = sel_req.wdata;
  end

  // Owner of the transfer, 1 selects master 1
  always_ff @(posedge xbus_clock or posedge xbus_reset) begin
    if (xbus_reset) begin
      owner_q <= 1'b0;
    end else if (access.valid) begin
      owner_q <= grant[1];
    end
  end

  // Response routing ------------------------------
  always_comb begin
    m0_rsp       = '0;
    m1_rsp       = '0;
    m0_rsp.grant = grant[0];
    m1_rsp.grant = grant[1];
    if (result.done) begin
      if (owner_q) begin
        m1_rsp.done  = 1'b1;
        m1_rsp.error = result.error;
        m1_rsp.rdata = result.rdata;
      end else begin
        m0_rsp.done  = 1'b1;
        m0_rsp.error = result.error;
        m0_rsp.rdata = result.rdata;
      end
    end
  end

  // Closes the data phase in the arbiter
  assign done = result.done;

  // Access only in ADDRESS and only for a master still requesting
  access_in_address_a: assert property (
    @(posedge xbus_clock) disable iff (xbus_reset)
    access.valid |-> phase == xbus_pkg::ADDRESS && sel_req.request
  );

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the XBus testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module xbus_tb -f xbus_regs.f -o Vxbus_tb

# A $fatal exit is judged from the log below
./obj_dir/Vxbus_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
  exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi

//--- test/xbus_tb.sv
/*
 * XBus subsystem testbench
 * Two random masters against a register model, with bus timing checks
 */
`timescale 1ns/1ps
`include "xbus_consts.svh"

module xbus_tb;

  localparam int GRANT_TIMEOUT = 2000;
  localparam int DONE_TIMEOUT  = 8;

  logic                       xbus_clock;
  logic                       xbus_reset;
  xbus_pkg::xbus_master_req_t m0_req;
  xbus_pkg::xbus_master_req_t m1_req;
  xbus_pkg::xbus_master_rsp_t m0_rsp;
  xbus_pkg::xbus_master_rsp_t m1_rsp;

  int         seed;
  int         done_order [$];
  logic [2:0] m_ptr;
  logic [7:0] m_config;
  logic [7:0] m_user;
  logic [7:0] m_ind [8];
  logic [7:0] m_rw [4];
  logic [7:0] m_mem [`XBUS_MEM_DEPTH];

  xbus_subsystem_top dut_i (
    .xbus_clock (xbus_clock),
    .xbus_reset (xbus_reset),
    .m0_req     (m0_req),
    .m1_req     (m1_req),
    .m0_rsp     (m0_rsp),
    .m1_rsp     (m1_rsp)
  );

  initial begin
    xbus_clock = 1'b0;
    forever #4 xbus_clock = ~xbus_clock;
  end

  task automatic check(input string name, input logic [15:0] actual,
                       input logic [15:0] expected);
    if (actual !== expected) begin
      $display("error %s: actual %h, expected %h", name, actual, expected);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout: %s", what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // Register model ------------------------------
  function automatic bit in_block(input logic [15:0] addr, input logic [15:0] base);
    return addr >= base && addr < base + 16'd4;
  endfunction

  function automatic bit mapped(input logic [15:0] addr);
    return (addr >= `XBUS_ADDR_PTR && addr <= `XBUS_ADDR_INDIRECT) ||
           (addr >= `XBUS_ADDR_RW_BASE && addr < `XBUS_ADDR_WO_BASE + 16'd4) ||
           (addr >= `XBUS_ADDR_MEM_BASE &&
            addr < `XBUS_ADDR_MEM_BASE + 16'(`XBUS_MEM_DEPTH));
  endfunction

  function automatic void model_reset();
    m_ptr    = 3'(`XBUS_RST_PTR);
    m_config = `XBUS_RST_CONFIG;
    m_user   = 8'h00;
    for (int i = 0; i < 8; i++) begin
      m_ind[i] = 8'h00;
    end
    for (int i = 0; i < 4; i++) begin
      m_rw[i] = `XBUS_RST_RW;
    end
  endfunction

  function automatic logic [7:0] model_read(input logic [15:0] addr);
    if (addr == `XBUS_ADDR_PTR) begin
      return {5'b00000, m_ptr};
    end else if (addr == `XBUS_ADDR_CONFIG) begin
      return m_config;
    end else if (addr == `XBUS_ADDR_USER) begin
      return m_user;
    end else if (addr == `XBUS_ADDR_SHARED) begin
      return `XBUS_RST_SHARED_RD;
    end else if (addr == `XBUS_ADDR_INDIRECT) begin
      return m_ind[m_ptr];
    end else if (in_block(addr, `XBUS_ADDR_RW_BASE)) begin
      return m_rw[addr[1:0]];
    end else if (in_block(addr, `XBUS_ADDR_RO_BASE)) begin
      return `XBUS_RST_RO;
    end else if (addr >= `XBUS_ADDR_MEM_BASE) begin
      return m_mem[addr[7:0]];
    end
    // Write-only block
    return 8'h00;
  endfunction

  // Shared, read-only and write-only writes leave nothing readable
  function automatic void model_write(input logic [15:0] addr, input logic [7:0] data);
    if (addr == `XBUS_ADDR_PTR) begin
      m_ptr = data[2:0];
    end else if (addr == `XBUS_ADDR_CONFIG) begin
      m_config = data;
    end else if (addr == `XBUS_ADDR_USER) begin
      m_user = m_user + 8'd1;
    end else if (addr == `XBUS_ADDR_INDIRECT) begin
      m_ind[m_ptr] = data;
    end else if (in_block(addr, `XBUS_ADDR_RW_BASE)) begin
      m_rw[addr[1:0]] = data;
    end else if (addr >= `XBUS_ADDR_MEM_BASE) begin
      m_mem[addr[7:0]] = data;
    end
  endfunction

  // Master side ------------------------------
  task automatic transfer(input int m, input bit rd, input logic [15:0] addr,
                          input logic [7:0] wdata);
    xbus_pkg::xbus_master_req_t cmd;
    xbus_pkg::xbus_master_rsp_t rsp;
    logic [7:0]                 exp_rdata;
    bit                         exp_error;
    int                         n;
    cmd = '{request: 1'b1, read: rd, write: !rd, addr: addr, wdata: wdata};
    @(posedge xbus_clock);
    if (m == 0) begin
      m0_req <= cmd;
    end else begin
      m1_req <= cmd;
    end
    n = 0;
    do begin
      @(negedge xbus_clock);
      rsp = (m == 0) ? m0_rsp : m1_rsp;
      n++;
    end while (!rsp.grant && n < GRANT_TIMEOUT);
    if (!rsp.grant) begin
      stop_on_timeout($sformatf("master %0d got no grant for address %h", m, addr));
    end
    n = 0;
    do begin
      @(negedge xbus_clock);
      rsp = (m == 0) ? m0_rsp : m1_rsp;
      n++;
    end while (!rsp.done && n < DONE_TIMEOUT);
    if (!rsp.done) begin
      stop_on_timeout($sformatf("master %0d got no done for address %h", m, addr));
    end
    exp_error = !mapped(addr);
    exp_rdata = (rd && !exp_error) ? model_read(addr) : 8'h00;
    check($sformatf("m%0d_rsp.error at %h", m, addr), 16'(rsp.error), 16'(exp_error));
    check($sformatf("m%0d_rsp.rdata at %h", m, addr), 16'(rsp.rdata), 16'(exp_rdata));
    if (!rd && !exp_error) begin
      model_write(addr, wdata);
    end
    done_order.push_back(m);
    @(posedge xbus_clock);
    if (m == 0) begin
      m0_req <= '0;
    end else begin
      m1_req <= '0;
    end
  endtask

  task automatic rand_below(input int n, output int value);
    value = ($random(seed) & 32'h7FFF_FFFF) % n;
  endtask

  function automatic logic [15:0] unmapped_addr(input int idx);
    case (idx % 6)
      0: return 16'h0000;
      1: return 16'h100D;
      2: return 16'h101C;
      3: return 16'h10FF;
      4: return 16'h1200;
      default: return 16'hFFFF;
    endcase
  endfunction

  task automatic pick_address(output logic [15:0] addr);
    int kind;
    int idx;
    rand_below(10, kind);
    rand_below(256, idx);
    case (kind)
      0: addr = `XBUS_ADDR_PTR;
      1: addr = `XBUS_ADDR_CONFIG;
      2: addr = `XBUS_ADDR_USER;
      3: addr = `XBUS_ADDR_SHARED;
      4: addr = `XBUS_ADDR_INDIRECT;
      5: addr = `XBUS_ADDR_RW_BASE + 16'(idx % 4);
      6: addr = `XBUS_ADDR_RO_BASE + 16'(idx % 4);
      7: addr = `XBUS_ADDR_WO_BASE + 16'(idx % 4);
      8: addr = `XBUS_ADDR_MEM_BASE + 16'(idx);
      default: addr = unmapped_addr(idx);
    endcase
  endtask

  task automatic random_master(input int m, input int count);
    logic [15:0] addr;
    int          gap;
    int          rd;
    int          data;
    for (int i = 0; i < count; i++) begin
      rand_below(4, gap);
      repeat (gap) @(posedge xbus_clock);
      pick_address(addr);
      rand_below(2, rd);
      rand_below(256, data);
      transfer(m, rd == 1, addr, 8'(data));
    end
  endtask

  // Every register outside the memory, through one master
  task automatic read_regs(input int m);
    transfer(m, 1'b1, `XBUS_ADDR_PTR, 8'h00);
    transfer(m, 1'b1, `XBUS_ADDR_CONFIG, 8'h00);
    transfer(m, 1'b1, `XBUS_ADDR_USER, 8'h00);
    transfer(m, 1'b1, `XBUS_ADDR_SHARED, 8'h00);
    transfer(m, 1'b1, `XBUS_ADDR_INDIRECT, 8'h00);
    for (int i = 0; i < 4; i++) begin
      transfer(m, 1'b1, `XBUS_ADDR_RW_BASE + 16'(i), 8'h00);
      transfer(m, 1'b1, `XBUS_ADDR_RO_BASE + 16'(i), 8'h00);
      transfer(m, 1'b1, `XBUS_ADDR_WO_BASE + 16'(i), 8'h00);
    end
  endtask

  // Bus monitor ------------------------------
  // Done one cycle after grant, only for the granted master
  initial begin
    logic prev_g0;
    logic prev_g1;
    logic prev_req0;
    prev_g0   = 1'b0;
    prev_g1   = 1'b0;
    prev_req0 = 1'b0;
    forever begin
      @(negedge xbus_clock);
      if (xbus_reset === 1'b0) begin
        check("grant overlap", 16'(m0_rsp.grant & m1_rsp.grant), 16'h0000);
        check("m0_rsp.done", 16'(m0_rsp.done), 16'(prev_g0));
        check("m1_rsp.done", 16'(m1_rsp.done), 16'(prev_g1));
        if (!m0_rsp.done) begin
          check("m0_rsp.rdata idle", 16'(m0_rsp.rdata), 16'h0000);
        end
        if (!m1_rsp.done) begin
          check("m1_rsp.rdata idle", 16'(m1_rsp.rdata), 16'h0000);
        end
        // Master 1 only wins when master 0 was quiet
        if (m1_rsp.grant) begin
          check("m0_req.request at m1 grant", 16'(prev_req0), 16'h0000);
        end
      end
      prev_g0   = m0_rsp.grant;
      prev_g1   = m1_rsp.grant;
      prev_req0 = m0_req.request;
    end
  end

  // Test sequence ------------------------------
  initial begin
    logic [15:0] addr;
    seed = 90503;
    xbus_reset <= 1'b1;
    m0_req     <= '0;
    m1_req     <= '0;
    model_reset();
    repeat (4) @(posedge xbus_clock);
    xbus_reset <= 1'b0;

    read_regs(0);

    // Memory fill
    for (int i = 0; i < `XBUS_MEM_DEPTH; i++) begin
      addr = `XBUS_ADDR_MEM_BASE + 16'(i);
      transfer(0, 1'b0, addr, addr[7:0] ^ {addr[3:0], addr[7:4]} ^ addr[15:8]);
    end

    // Both masters at once, master 0 first
    done_order.delete();
    fork
      transfer(0, 1'b1, `XBUS_ADDR_RW_BASE, 8'h00);
      transfer(1, 1'b1, `XBUS_ADDR_CONFIG, 8'h00);
    join
    check("first done master", 16'(done_order[0]), 16'h0000);
    check("second done master", 16'(done_order[1]), 16'h0001);

    fork
      random_master(0, 80);
      random_master(1, 80);
    join

    // Indirect entries through every pointer value
    for (int p = 0; p < 8; p++) begin
      transfer(1, 1'b0, `XBUS_ADDR_PTR, 8'(p));
      transfer(1, 1'b0, `XBUS_ADDR_INDIRECT, 8'(p * 37 + 11));
    end
    for (int p = 0; p < 8; p++) begin
      transfer(1, 1'b0, `XBUS_ADDR_PTR, 8'(p) | 8'hF8);
      transfer(1, 1'b1, `XBUS_ADDR_INDIRECT, 8'h00);
    end

    for (int i = 0; i < 6; i++) begin
      transfer(0, 1'b0, unmapped_addr(i), 8'hFF);
      transfer(1, 1'b1, unmapped_addr(i), 8'h00);
    end
    read_regs(1);

    $display("Simulation passed");
    $finish;
  end

endmodule

//--- xbus_regs.f
+incdir+include
rtl/xbus_pkg.sv
rtl/xbus_arbiter.sv
rtl/xbus_transfer_control.sv
rtl/xbus_register_file.sv
rtl/xbus_subsystem_top.sv
test/xbus_tb.sv
